//--- Makefile
SOURCES := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vtb_lane
	@out="$$(./obj_dir/Vtb_lane)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation finished: PASS'

obj_dir/Vtb_lane: files.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lane \
	  -f files.f -Mdir obj_dir

clean:
	rm -rf obj_dir

//--- design/elem_counter.sv
// Element index counter with load, advance and last-element flag

`timescale 1ns/100ps

module elem_counter #(
  parameter int unsigned NrElems = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           load_i,
  input  logic [$clog2(NrElems):0]       vl_i,
  input  logic                           advance_i,
  output logic [$clog2(NrElems)-1:0]     idx_o,
  output logic                           last_o
);

  localparam int unsigned IdxW = $clog2(NrElems);

  logic [IdxW-1:0] idx_q;
  logic [IdxW:0]   vl_q;
  // Set once the last element has been advanced past
  logic            spent_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q   <= '0;
      vl_q    <= '0;
      spent_q <= 1'b0;
    end else if (load_i) begin
      idx_q   <= '0;
      vl_q    <= vl_i;
      spent_q <= 1'b0;
    end else if (advance_i) begin
      // Hold on the final element
      if (!last_o) begin
        idx_q <= idx_q + 1'b1;
      end else begin
        spent_q <= 1'b1;
      end
    end
  end

  assign idx_o  = idx_q;
  assign last_o = ({1'b0, idx_q} == (vl_q - 1'b1));

  a_no_advance_after_last: assert property (
    @(posedge clk_i) disable iff (!rst_ni) advance_i |-> !spent_q
  ) else $error("elem_counter: advance after last element without reload");

endmodule : elem_counter

//--- design/lane.sv
// Lane top level with sequencer, element counter, register file and execution unit

`timescale 1ns/100ps

module lane #(
  parameter int unsigned NrElems = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Instruction interface
  input  logic                           pe_req_valid_i,
  input  lane_pkg::vop_e                 pe_req_op_i,
  input  lane_pkg::vreg_t                pe_req_vd_i,
  input  lane_pkg::vreg_t                pe_req_vs1_i,
  input  lane_pkg::vreg_t                pe_req_vs2_i,
  input  logic [$clog2(NrElems):0]       pe_req_vl_i,
  output logic                           pe_req_ready_o,
  output logic                           vinsn_done_o,
  // Store unit
  output lane_pkg::elen_t                stu_operand_o,
  output logic                           stu_operand_valid_o,
  input  logic                           stu_operand_ready_i,
  // Load unit
  input  logic                           ldu_result_req_i,
  input  lane_pkg::vreg_t                ldu_result_vreg_i,
  input  logic [$clog2(NrElems)-1:0]     ldu_result_elem_i,
  input  lane_pkg::elen_t                ldu_result_wdata_i,
  input  lane_pkg::strb_t                ldu_result_be_i,
  output logic                           ldu_result_gnt_o
);

  localparam int unsigned IdxW = $clog2(NrElems);

  logic            cnt_load;
  logic            cnt_advance;
  logic            cnt_last;
  logic [IdxW-1:0] cnt_idx;
  logic            issue_valid;
  lane_pkg::vreg_t issue_vs1;
  lane_pkg::vreg_t issue_vs2;
  lane_pkg::vop_e  exec_op;
  lane_pkg::vreg_t exec_vd;
  logic            stu_buf_free;
  logic            stu_handshake;
  lane_pkg::elen_t rd_data1;
  lane_pkg::elen_t rd_data2;
  logic            alu_we;
  lane_pkg::vreg_t alu_vd;
  logic [IdxW-1:0] alu_idx;
  lane_pkg::elen_t alu_wdata;

  ////////////////////
  // Control
  ////////////////////

  lane_sequencer #(.NrElems(NrElems)) i_lane_sequencer (
    .clk_i          (clk_i         ),
    .rst_ni         (rst_ni        ),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_op_i    (pe_req_op_i   ),
    .pe_req_vd_i    (pe_req_vd_i   ),
    .pe_req_vs1_i   (pe_req_vs1_i  ),
    .pe_req_vs2_i   (pe_req_vs2_i  ),
    .pe_req_vl_i    (pe_req_vl_i   ),
    .pe_req_ready_o (pe_req_ready_o),
    .vinsn_done_o   (vinsn_done_o  ),
    .cnt_load_o     (cnt_load      ),
    .cnt_advance_o  (cnt_advance   ),
    .cnt_last_i     (cnt_last      ),
    .issue_valid_o  (issue_valid   ),
    .issue_vs1_o    (issue_vs1     ),
    .issue_vs2_o    (issue_vs2     ),
    .exec_op_o      (exec_op       ),
    .exec_vd_o      (exec_vd       ),
    .stu_buf_free_i (stu_buf_free  ),
    .stu_handshake_i(stu_handshake )
  );

  elem_counter #(.NrElems(NrElems)) i_elem_counter (
    .clk_i    (clk_i      ),
    .rst_ni   (rst_ni     ),
    .load_i   (cnt_load   ),
    .vl_i     (pe_req_vl_i),
    .advance_i(cnt_advance),
    .idx_o    (cnt_idx    ),
    .last_o   (cnt_last   )
  );

  ////////////////////
  // Datapath
  ////////////////////

  vector_regfile #(.NrElems(NrElems)) i_vrf (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .rd_en_i           (issue_valid       ),
    .rd_idx_i          (cnt_idx           ),
    .rd_vs1_i          (issue_vs1         ),
    .rd_vs2_i          (issue_vs2         ),
    .rd_data1_o        (rd_data1          ),
    .rd_data2_o        (rd_data2          ),
    .alu_we_i          (alu_we            ),
    .alu_vd_i          (alu_vd            ),
    .alu_idx_i         (alu_idx           ),
    .alu_wdata_i       (alu_wdata         ),
    .ldu_result_req_i  (ldu_result_req_i  ),
    .ldu_result_vreg_i (ldu_result_vreg_i ),
    .ldu_result_elem_i (ldu_result_elem_i ),
    .ldu_result_wdata_i(ldu_result_wdata_i),
    .ldu_result_be_i   (ldu_result_be_i   ),
    .ldu_result_gnt_o  (ldu_result_gnt_o  )
  );

  // Port 2 carries vs2, the left-hand ALU operand
  vector_exec_unit #(.NrElems(NrElems)) i_exec (
    .clk_i              (clk_i              ),
    .rst_ni             (rst_ni             ),
    .issue_valid_i      (issue_valid        ),
    .issue_idx_i        (cnt_idx            ),
    .op_i               (exec_op            ),
    .vd_i               (exec_vd            ),
    .opa_i              (rd_data2           ),
    .opb_i              (rd_data1           ),
    .alu_we_o           (alu_we             ),
    .alu_vd_o           (alu_vd             ),
    .alu_idx_o          (alu_idx            ),
    .alu_wdata_o        (alu_wdata          ),
    .stu_operand_o      (stu_operand_o      ),
    .stu_operand_valid_o(stu_operand_valid_o),
    .stu_operand_ready_i(stu_operand_ready_i),
    .stu_buf_free_o     (stu_buf_free       ),
    .stu_handshake_o    (stu_handshake      )
  );

endmodule : lane

//--- design/lane_pkg.sv
// Element, strobe, register-index, opcode and sequencer-state types for the lane

package lane_pkg;

  ////////////////////
  // Datapath widths
  ////////////////////

  // One vector element
  typedef logic [63:0] elen_t;

  // Byte enables of one element
  typedef logic [7:0] strb_t;

  // Vector register index, 32 registers
  typedef logic [4:0] vreg_t;

  ////////////////////
  // Instructions
  ////////////////////

  // Element-wise ops compute vd = vs2 op vs1, the store streams vs2 out
  typedef enum logic [2:0] {
    VOP_ADD   = 3'd0,
    VOP_SUB   = 3'd1,
    VOP_AND   = 3'd2,
    VOP_OR    = 3'd3,
    VOP_XOR   = 3'd4,
    VOP_STORE = 3'd5
  } vop_e;

  // Instruction control FSM
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_ALU_RUN    = 3'd1,
    ST_ALU_DRAIN  = 3'd2,
    ST_DONE       = 3'd3,
    ST_STORE_RUN  = 3'd4,
    ST_STORE_DONE = 3'd5
  } seq_state_e;

endpackage : lane_pkg

//--- design/lane_sequencer.sv
// Instruction-control FSM issuing element reads and signalling completion

`timescale 1ns/100ps

module lane_sequencer #(
  parameter int unsigned NrElems = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction from the main sequencer
  input  logic                     pe_req_valid_i,
  input  lane_pkg::vop_e           pe_req_op_i,
  input  lane_pkg::vreg_t          pe_req_vd_i,
  input  lane_pkg::vreg_t          pe_req_vs1_i,
  input  lane_pkg::vreg_t          pe_req_vs2_i,
  input  logic [$clog2(NrElems):0] pe_req_vl_i,
  output logic                     pe_req_ready_o,
  output logic                     vinsn_done_o,
  // Element counter
  output logic                     cnt_load_o,
  output logic                     cnt_advance_o,
  input  logic                     cnt_last_i,
  // Read issue
  output logic                     issue_valid_o,
  output lane_pkg::vreg_t          issue_vs1_o,
  output lane_pkg::vreg_t          issue_vs2_o,
  // Execution unit
  output lane_pkg::vop_e           exec_op_o,
  output lane_pkg::vreg_t          exec_vd_o,
  input  logic                     stu_buf_free_i,
  input  logic                     stu_handshake_i
);

  lane_pkg::seq_state_e state_q, state_d;
  lane_pkg::vop_e       op_q;
  lane_pkg::vreg_t      vd_q;
  lane_pkg::vreg_t      vs1_q;
  lane_pkg::vreg_t      vs2_q;
  logic                 drain_q;
  // A store read was issued last cycle and its data is not yet in the store register
  logic                 rd_pending_q;
  logic                 accept;

  assign pe_req_ready_o = (state_q == lane_pkg::ST_IDLE);
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign cnt_load_o     = accept;
  assign vinsn_done_o   = (state_q == lane_pkg::ST_DONE);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d       = state_q;
    issue_valid_o = 1'b0;
    cnt_advance_o = 1'b0;
    unique case (state_q)
      lane_pkg::ST_IDLE: begin
        if (accept) begin
          state_d = (pe_req_op_i == lane_pkg::VOP_STORE) ? lane_pkg::ST_STORE_RUN
                                                         : lane_pkg::ST_ALU_RUN;
        end
      end
      // One element per cycle
      lane_pkg::ST_ALU_RUN: begin
        issue_valid_o = 1'b1;
        cnt_advance_o = 1'b1;
        if (cnt_last_i) begin
          state_d = lane_pkg::ST_ALU_DRAIN;
        end
      end
      // Two cycles for the last result to reach the register file
      lane_pkg::ST_ALU_DRAIN: begin
        if (drain_q) begin
          state_d = lane_pkg::ST_DONE;
        end
      end
      lane_pkg::ST_DONE: begin
        state_d = lane_pkg::ST_IDLE;
      end
      lane_pkg::ST_STORE_RUN: begin
        if (!rd_pending_q && stu_buf_free_i) begin
          issue_valid_o = 1'b1;
          cnt_advance_o = 1'b1;
          if (cnt_last_i) begin
            state_d = lane_pkg::ST_STORE_DONE;
          end
        end
      end
      // Only the last element can still be handed over here
      lane_pkg::ST_STORE_DONE: begin
        if (stu_handshake_i) begin
          state_d = lane_pkg::ST_DONE;
        end
      end
      default: state_d = lane_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= lane_pkg::ST_IDLE;
      op_q         <= lane_pkg::VOP_ADD;
      drain_q      <= 1'b0;
      rd_pending_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      drain_q      <= (state_q == lane_pkg::ST_ALU_DRAIN) && !drain_q;
      rd_pending_q <= issue_valid_o;
      if (accept) begin
        op_q <= pe_req_op_i;
      end
    end
  end

  // Register operands of the running instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q  <= pe_req_vd_i;
      vs1_q <= pe_req_vs1_i;
      vs2_q <= pe_req_vs2_i;
    end
  end

  assign issue_vs1_o = vs1_q;
  assign issue_vs2_o = vs2_q;
  assign exec_op_o   = op_q;
  assign exec_vd_o   = vd_q;

  a_vl_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> (pe_req_vl_i >= 1) && (pe_req_vl_i <= NrElems)
  ) else $error("lane_sequencer: vl out of range at acceptance");

endmodule : lane_sequencer

//--- design/vector_exec_unit.sv
// Integer ALU pipeline with write-back and the store operand register

`timescale 1ns/100ps

module vector_exec_unit #(
  parameter int unsigned NrElems = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // From the sequencer
  input  logic                           issue_valid_i,
  input  logic [$clog2(NrElems)-1:0]     issue_idx_i,
  input  lane_pkg::vop_e                 op_i,
  input  lane_pkg::vreg_t                vd_i,
  // Operands, opa is vs2 and opb is vs1
  input  lane_pkg::elen_t                opa_i,
  input  lane_pkg::elen_t                opb_i,
  // Write-back
  output logic                           alu_we_o,
  output lane_pkg::vreg_t                alu_vd_o,
  output logic [$clog2(NrElems)-1:0]     alu_idx_o,
  output lane_pkg::elen_t                alu_wdata_o,
  // Store unit
  output lane_pkg::elen_t                stu_operand_o,
  output logic                           stu_operand_valid_o,
  input  logic                           stu_operand_ready_i,
  // Status
  output logic                           stu_buf_free_o,
  output logic                           stu_handshake_o
);

  localparam int unsigned IdxW = $clog2(NrElems);

  // Issue tag, aligned with the register read data
  logic            tag_valid_q;
  logic [IdxW-1:0] tag_idx_q;
  logic            tag_is_store;

  logic            res_valid_q;
  logic [IdxW-1:0] res_idx_q;
  lane_pkg::vreg_t res_vd_q;
  lane_pkg::elen_t res_data_q;
  lane_pkg::elen_t alu_res;

  lane_pkg::elen_t stu_q;
  logic            stu_valid_q;

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    unique case (op_i)
      lane_pkg::VOP_ADD: alu_res = opa_i + opb_i;
      lane_pkg::VOP_SUB: alu_res = opa_i - opb_i;
      lane_pkg::VOP_AND: alu_res = opa_i & opb_i;
      lane_pkg::VOP_OR:  alu_res = opa_i | opb_i;
      lane_pkg::VOP_XOR: alu_res = opa_i ^ opb_i;
      default:           alu_res = opa_i;
    endcase
  end

  assign tag_is_store = (op_i == lane_pkg::VOP_STORE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_valid_q <= 1'b0;
      res_valid_q <= 1'b0;
      stu_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= issue_valid_i;
      res_valid_q <= tag_valid_q && !tag_is_store;
      // Sequencer only reads when the register is free or draining
      if (tag_valid_q && tag_is_store) begin
        stu_valid_q <= 1'b1;
      end else if (stu_handshake_o) begin
        stu_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    tag_idx_q  <= issue_idx_i;
    res_idx_q  <= tag_idx_q;
    res_vd_q   <= vd_i;
    res_data_q <= alu_res;
    if (tag_valid_q && tag_is_store) begin
      stu_q <= opa_i;
    end
  end

  assign alu_we_o    = res_valid_q;
  assign alu_vd_o    = res_vd_q;
  assign alu_idx_o   = res_idx_q;
  assign alu_wdata_o = res_data_q;

  assign stu_operand_o       = stu_q;
  assign stu_operand_valid_o = stu_valid_q;
  assign stu_handshake_o     = stu_valid_q && stu_operand_ready_i;
  assign stu_buf_free_o      = !stu_valid_q || stu_operand_ready_i;

  a_stu_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stu_operand_valid_o && !stu_operand_ready_i |=> stu_operand_valid_o && $stable(stu_operand_o)
  ) else $error("vector_exec_unit: store operand changed under back-pressure");

endmodule : vector_exec_unit

//--- design/vector_regfile.sv
// Vector register file with two registered read ports and an ALU-first write port

`timescale 1ns/100ps

module vector_regfile #(
  parameter int unsigned NrElems = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Operand read
  input  logic                           rd_en_i,
  input  logic [$clog2(NrElems)-1:0]     rd_idx_i,
  input  lane_pkg::vreg_t                rd_vs1_i,
  input  lane_pkg::vreg_t                rd_vs2_i,
  output lane_pkg::elen_t                rd_data1_o,
  output lane_pkg::elen_t                rd_data2_o,
  // ALU write-back
  input  logic                           alu_we_i,
  input  lane_pkg::vreg_t                alu_vd_i,
  input  logic [$clog2(NrElems)-1:0]     alu_idx_i,
  input  lane_pkg::elen_t                alu_wdata_i,
  // Load unit
  input  logic                           ldu_result_req_i,
  input  lane_pkg::vreg_t                ldu_result_vreg_i,
  input  logic [$clog2(NrElems)-1:0]     ldu_result_elem_i,
  input  lane_pkg::elen_t                ldu_result_wdata_i,
  input  lane_pkg::strb_t                ldu_result_be_i,
  output logic                           ldu_result_gnt_o
);

  localparam int unsigned NrBytes = $bits(lane_pkg::strb_t);

  // Flat storage, address is {register, element}
  lane_pkg::elen_t mem [32*NrElems];
  lane_pkg::elen_t rd_data1_q;
  lane_pkg::elen_t rd_data2_q;

  // ALU write-back wins the single write port
  assign ldu_result_gnt_o = ldu_result_req_i && !alu_we_i;

  always_ff @(posedge clk_i) begin
    if (alu_we_i) begin
      mem[{alu_vd_i, alu_idx_i}] <= alu_wdata_i;
    end else if (ldu_result_req_i) begin
      for (int b = 0; b < NrBytes; b++) begin
        if (ldu_result_be_i[b]) begin
          mem[{ldu_result_vreg_i, ldu_result_elem_i}][8*b +: 8] <= ldu_result_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data1_q <= '0;
      rd_data2_q <= '0;
    end else if (rd_en_i) begin
      rd_data1_q <= mem[{rd_vs1_i, rd_idx_i}];
      rd_data2_q <= mem[{rd_vs2_i, rd_idx_i}];
    end
  end

  assign rd_data1_o = rd_data1_q;
  assign rd_data2_o = rd_data2_q;

endmodule : vector_regfile

//--- files.f
design/lane_pkg.sv
design/elem_counter.sv
design/lane_sequencer.sv
design/vector_regfile.sv
design/vector_exec_unit.sv
design/lane.sv
test/tb_lane.sv

//--- test/tb_lane.sv
// Testbench for the lane with clock, reset, watchdog, checker, register model and directed tests

`timescale 1ns/100ps

module tb_lane;

  localparam int unsigned NrElems   = 8;
  localparam int unsigned IdxW      = $clog2(NrElems);
  localparam int unsigned ClkPeriod = 4;
  localparam int unsigned RstCycles = 8;
  localparam int unsigned WaitLimit = 4 * NrElems + 20;
  localparam int unsigned Seed      = 32'h7e70_7ed7;
  // Reset, load/store, ALU ops, ALU timing, back-pressure, load during ALU
  localparam int unsigned TestCycles = (RstCycles + 4) + (10 * NrElems + 12) +
                                       (35 * NrElems + 56) + (3 * NrElems + 18) +
                                       (4 * NrElems + 8) + (8 * NrElems + 12);
  localparam int unsigned WatchdogCycles = 2 * TestCycles;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   pe_req_valid_i;
  lane_pkg::vop_e         pe_req_op_i;
  lane_pkg::vreg_t        pe_req_vd_i;
  lane_pkg::vreg_t        pe_req_vs1_i;
  lane_pkg::vreg_t        pe_req_vs2_i;
  logic [IdxW:0]          pe_req_vl_i;
  logic                   pe_req_ready_o;
  logic                   vinsn_done_o;
  lane_pkg::elen_t        stu_operand_o;
  logic                   stu_operand_valid_o;
  logic                   stu_operand_ready_i;
  logic                   ldu_result_req_i;
  lane_pkg::vreg_t        ldu_result_vreg_i;
  logic [IdxW-1:0]        ldu_result_elem_i;
  lane_pkg::elen_t        ldu_result_wdata_i;
  lane_pkg::strb_t        ldu_result_be_i;
  logic                   ldu_result_gnt_o;

  // Expected register contents
  lane_pkg::elen_t model [32][NrElems];
  int unsigned     errors;
  int unsigned     checks;

  lane #(.NrElems(NrElems)) lane_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // vd = vs2 op vs1
  function automatic lane_pkg::elen_t expected_result(input lane_pkg::vop_e op,
                                                      input lane_pkg::elen_t vs2,
                                                      input lane_pkg::elen_t vs1);
    case (op)
      lane_pkg::VOP_ADD: return vs2 + vs1;
      lane_pkg::VOP_SUB: return vs2 - vs1;
      lane_pkg::VOP_AND: return vs2 & vs1;
      lane_pkg::VOP_OR:  return vs2 | vs1;
      default:           return vs2 ^ vs1;
    endcase
  endfunction

  // Every task here starts and ends on a falling edge
  task automatic load_elem(input lane_pkg::vreg_t vr, input int idx, input lane_pkg::elen_t data,
                           input lane_pkg::strb_t be);
    int waited;
    waited = 0;
    ldu_result_req_i   = 1'b1;
    ldu_result_vreg_i  = vr;
    ldu_result_elem_i  = idx[IdxW-1:0];
    ldu_result_wdata_i = data;
    ldu_result_be_i    = be;
    #1;
    while (!ldu_result_gnt_o && waited < WaitLimit) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (ldu_result_gnt_o) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
          model[vr][idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end else begin
      report_failure($sformatf("load to v%0d element %0d was never granted", vr, idx));
    end
    @(negedge clk_i);
    ldu_result_req_i = 1'b0;
  endtask

  task automatic fill_reg(input lane_pkg::vreg_t vr);
    for (int i = 0; i < NrElems; i++) begin
      load_elem(vr, i, {$urandom, $urandom}, 8'hff);
    end
  endtask

  task automatic issue_insn(input lane_pkg::vop_e op, input lane_pkg::vreg_t vd,
                            input lane_pkg::vreg_t vs1, input lane_pkg::vreg_t vs2,
                            input int vl);
    int waited;
    waited = 0;
    pe_req_valid_i = 1'b1;
    pe_req_op_i    = op;
    pe_req_vd_i    = vd;
    pe_req_vs1_i   = vs1;
    pe_req_vs2_i   = vs2;
    pe_req_vl_i    = vl[IdxW:0];
    #1;
    while (!pe_req_ready_o && waited < WaitLimit) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!pe_req_ready_o) begin
      report_failure("instruction was never accepted by the lane");
    end
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  task automatic alu_insn(input lane_pkg::vop_e op, input lane_pkg::vreg_t vd,
                          input lane_pkg::vreg_t vs1, input lane_pkg::vreg_t vs2, input int vl);
    int waited;
    waited = 0;
    for (int i = 0; i < vl; i++) begin
      model[vd][i] = expected_result(op, model[vs2][i], model[vs1][i]);
    end
    issue_insn(op, vd, vs1, vs2, vl);
    #1;
    while (!vinsn_done_o && waited < WaitLimit) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!vinsn_done_o) begin
      report_failure("ALU instruction never signalled done");
    end
    @(negedge clk_i);
  endtask

  // Streams vs2 out and compares each element with the model
  task automatic store_readback(input lane_pkg::vreg_t vs2, input int vl, input bit backpressure);
    int              got;
    int              cyc;
    int              last_hs;
    bit              stalled;
    bit              finished;
    got      = 0;
    cyc      = 0;
    last_hs  = -1;
    stalled  = 1'b0;
    finished = 1'b0;
    issue_insn(lane_pkg::VOP_STORE, 5'd0, 5'd0, vs2, vl);
    while (!finished && cyc < 2 * WaitLimit) begin
      stu_operand_ready_i = backpressure ? (($urandom % 3) != 0) : 1'b1;
      #1;
      // A stalled element stays offered until it is taken
      if (stalled) begin
        check("stu_operand_valid_o", stu_operand_valid_o, 1'b1);
        if (got < vl) begin
          check("stu_operand_o", stu_operand_o, model[vs2][got]);
        end
      end
      stalled = stu_operand_valid_o && !stu_operand_ready_i;
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        if (got < vl) begin
          check($sformatf("stu_operand_o element %0d", got), stu_operand_o, model[vs2][got]);
        end else begin
          report_failure("store stream delivered more elements than vl");
        end
        got++;
        last_hs = cyc;
      end
      if (vinsn_done_o) begin
        finished = 1'b1;
        check("store element count", 64'(got), 64'(vl));
        if (cyc != last_hs + 1) begin
          report_failure("store done did not follow the final handshake");
        end
      end
      @(negedge clk_i);
      cyc++;
    end
    stu_operand_ready_i = 1'b0;
    if (!finished) begin
      report_failure($sformatf("store of v%0d never signalled done", vs2));
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_state();
    #1;
    check("pe_req_ready_o", pe_req_ready_o, 1'b1);
    check("vinsn_done_o", vinsn_done_o, 1'b0);
    check("stu_operand_valid_o", stu_operand_valid_o, 1'b0);
    check("ldu_result_gnt_o", ldu_result_gnt_o, 1'b0);
    @(negedge clk_i);
  endtask

  task automatic load_store_readback();
    fill_reg(5'd1);
    fill_reg(5'd2);
    fill_reg(5'd5);
    // Partial writes on top of full ones
    for (int i = 0; i < NrElems; i++) begin
      load_elem(5'd5, i, {$urandom, $urandom}, lane_pkg::strb_t'($urandom));
    end
    load_elem(5'd2, 1, {$urandom, $urandom}, 8'h0f);
    load_elem(5'd1, 0, {$urandom, $urandom}, 8'h00);
    store_readback(5'd1, NrElems, 1'b0);
    store_readback(5'd2, NrElems, 1'b0);
    store_readback(5'd5, NrElems, 1'b0);
    store_readback(5'd5, NrElems / 2, 1'b0);
  endtask

  task automatic alu_operations();
    lane_pkg::vop_e ops [5];
    ops = '{lane_pkg::VOP_ADD, lane_pkg::VOP_SUB, lane_pkg::VOP_AND,
            lane_pkg::VOP_OR, lane_pkg::VOP_XOR};
    for (int k = 0; k < 5; k++) begin
      fill_reg(5'd6);
      fill_reg(5'd7);
      alu_insn(ops[k], lane_pkg::vreg_t'(8 + k), 5'd6, 5'd7, NrElems);
      store_readback(lane_pkg::vreg_t'(8 + k), NrElems, 1'b0);
    end
    // Destination overlapping vs2 and then vs1
    alu_insn(lane_pkg::VOP_SUB, 5'd7, 5'd6, 5'd7, NrElems);
    alu_insn(lane_pkg::VOP_ADD, 5'd6, 5'd6, 5'd8, NrElems);
    store_readback(5'd7, NrElems, 1'b0);
    store_readback(5'd6, NrElems, 1'b0);
  endtask

  // Cycle k is sampled after the k-th falling edge following the acceptance edge
  task automatic alu_timing(input int n);
    for (int i = 0; i < n; i++) begin
      model[9][i] = expected_result(lane_pkg::VOP_ADD, model[2][i], model[1][i]);
    end
    pe_req_valid_i = 1'b1;
    pe_req_op_i    = lane_pkg::VOP_ADD;
    pe_req_vd_i    = 5'd9;
    pe_req_vs1_i   = 5'd1;
    pe_req_vs2_i   = 5'd2;
    pe_req_vl_i    = n[IdxW:0];
    #1;
    check("pe_req_ready_o before acceptance", pe_req_ready_o, 1'b1);
    for (int cyc = 1; cyc <= n + 4; cyc++) begin
      @(negedge clk_i);
      pe_req_valid_i = 1'b0;
      #1;
      check($sformatf("pe_req_ready_o in cycle %0d", cyc), pe_req_ready_o, cyc >= n + 4);
      check($sformatf("vinsn_done_o in cycle %0d", cyc), vinsn_done_o, cyc == n + 3);
    end
    @(negedge clk_i);
  endtask

  task automatic alu_timing_test();
    alu_timing(NrElems);
    alu_timing(1);
    alu_timing(2);
    store_readback(5'd9, NrElems, 1'b0);
  endtask

  task automatic store_backpressure();
    fill_reg(5'd13);
    store_readback(5'd13, NrElems, 1'b1);
    store_readback(5'd13, NrElems - 1, 1'b1);
  endtask

  task automatic load_during_alu();
    lane_pkg::elen_t data [NrElems];
    int              sent;
    int              cyc;
    sent = 0;
    cyc  = 0;
    fill_reg(5'd3);
    fill_reg(5'd4);
    for (int i = 0; i < NrElems; i++) begin
      data[i]     = {$urandom, $urandom};
      model[12][i] = expected_result(lane_pkg::VOP_XOR, model[4][i], model[3][i]);
    end
    pe_req_valid_i = 1'b1;
    pe_req_op_i    = lane_pkg::VOP_XOR;
    pe_req_vd_i    = 5'd12;
    pe_req_vs1_i   = 5'd3;
    pe_req_vs2_i   = 5'd4;
    pe_req_vl_i    = NrElems[IdxW:0];
    while ((sent < NrElems || cyc <= NrElems + 3) && cyc < WaitLimit) begin
      ldu_result_req_i = (sent < NrElems);
      if (sent < NrElems) begin
        ldu_result_vreg_i  = 5'd20;
        ldu_result_elem_i  = sent[IdxW-1:0];
        ldu_result_wdata_i = data[sent];
        ldu_result_be_i    = 8'hff;
      end
      #1;
      // Write-back holds the port in cycles 3 to vl+2
      check($sformatf("ldu_result_gnt_o in cycle %0d", cyc), ldu_result_gnt_o,
            (sent < NrElems) && !(cyc >= 3 && cyc <= NrElems + 2));
      check($sformatf("vinsn_done_o in cycle %0d", cyc), vinsn_done_o, cyc == NrElems + 3);
      if (ldu_result_gnt_o && sent < NrElems) begin
        model[20][sent] = data[sent];
        sent++;
      end
      @(negedge clk_i);
      pe_req_valid_i = 1'b0;
      cyc++;
    end
    ldu_result_req_i = 1'b0;
    if (sent < NrElems) begin
      report_failure("loads held during the ALU instruction did not all complete");
    end
    store_readback(5'd20, NrElems, 1'b0);
    store_readback(5'd12, NrElems, 1'b0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(Seed));
    errors              = 0;
    checks              = 0;
    rst_ni              = 1'b0;
    pe_req_valid_i      = 1'b0;
    pe_req_op_i         = lane_pkg::VOP_ADD;
    pe_req_vd_i         = '0;
    pe_req_vs1_i        = '0;
    pe_req_vs2_i        = '0;
    pe_req_vl_i         = '0;
    stu_operand_ready_i = 1'b0;
    ldu_result_req_i    = 1'b0;
    ldu_result_vreg_i   = '0;
    ldu_result_elem_i   = '0;
    ldu_result_wdata_i  = '0;
    ldu_result_be_i     = '0;
    repeat (RstCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    load_store_readback();
    alu_operations();
    alu_timing_test();
    store_backpressure();
    load_during_alu();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_lane
